//--- hdl/cu_consts.svh
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// Opcodes
`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ADDI  6'b001000
`define OP_ADDIU 6'b001001
`define OP_SLTI  6'b001010
`define OP_SLTIU 6'b001011
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_XORI  6'b001110
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_SW    6'b101011

// Function codes of the R-type group
`define FN_ADD  6'b100000
`define FN_ADDU 6'b100001
`define FN_SUB  6'b100010
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_NOR  6'b100111
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

`define RS_HI 25
`define RS_LO 21
`define RT_HI 20
`define RT_LO 16
`define RD_HI 15
`define RD_LO 11
`define REG_W 5

`define OVF_VECTOR 9'd448 // Overflow handler in RAM
`define LINK_REG   5'd31

// Compare selects for the ALU
`define CMP_LT  4'b0000
`define CMP_LTU 4'b0001
`define CMP_EQ  4'b1000
`define CMP_NE  4'b1100

`endif

//--- hdl/cuPkg.sv
package cuPkg;

	typedef enum logic [4:0] {
		stReset,
		stFetchAddr,
		stFetchReq,
		stFetchWait,
		stLoadIr,
		stDecode,
		stAluExec,
		stOvfCheck,
		stMemAddr,
		stStoreData,
		stMemWait,
		stMdrLoad,
		stWriteBack,
		stBranch,
		stJump,
		stJumpLink
	} cuState_t;

	// What the decoder found, one path per class in the sequencer
	typedef enum logic [3:0] {
		icAluReg,
		icAluRegOvf,
		icAluImm,
		icAluImmOvf,
		icLoad,
		icStore,
		icBranch,
		icJump,
		icJumpLink,
		icInvalid
	} instrClass_t;

	// Codes as the ALU expects them
	typedef enum logic [3:0] {
		aluPass    = 4'b0000,
		aluAdd     = 4'b0001,
		aluAnd     = 4'b0100,
		aluOr      = 4'b0101,
		aluNor     = 4'b0110,
		aluLui     = 4'b1010,
		aluPcInc   = 4'b1011,
		aluXor     = 4'b1100,
		aluCompare = 4'b1101
	} aluOp_t;

	typedef enum logic [1:0] {
		bSelReg = 2'b00, // Register file port B
		bSelImm = 2'b01, // Extended imm16
		bSelMdr = 2'b10,
		bSelPc  = 2'b11  // PC path for fetch and link
	} aluBSel_t;

endpackage

//--- hdl/instrDecoder.sv
`timescale 1ns/10ps
`include "cu_consts.svh"

module instrDecoder import cuPkg::*; (
	input  logic [31:0]       instruction,
	output instrClass_t       instrClass,
	output logic [`REG_W-1:0] regFileRS,
	output logic [`REG_W-1:0] regFileRT,
	output logic [`REG_W-1:0] regFileRD,
	output aluOp_t            aluOperation,
	output logic [1:0]        aluSign, // Bit 1 signed, bit 0 subtract
	output logic [3:0]        cmpSignal,
	output logic              signExtend
);

	logic [5:0] opcode;
	logic [5:0] functionCode;

	assign opcode = instruction[31:26];
	assign functionCode = instruction[5:0];
	assign regFileRS = instruction[`RS_HI:`RS_LO];
	assign regFileRT = instruction[`RT_HI:`RT_LO];

	always_comb begin
		instrClass = icInvalid;
		aluOperation = aluPass;
		aluSign = 2'b00;
		cmpSignal = `CMP_LT;
		signExtend = 1'b1; // Most imm16 forms are signed
		case (opcode)
			`OP_RTYPE: begin
				instrClass = icAluReg;
				signExtend = 1'b0;
				case (functionCode)
					`FN_ADDU: aluOperation = aluAdd;
					`FN_ADD: begin
						instrClass = icAluRegOvf;
						aluOperation = aluAdd;
						aluSign = 2'b10;
					end
					`FN_SUBU: begin
						aluOperation = aluAdd;
						aluSign = 2'b01;
					end
					`FN_SUB: begin
						instrClass = icAluRegOvf;
						aluOperation = aluAdd;
						aluSign = 2'b11;
					end
					`FN_AND: aluOperation = aluAnd;
					`FN_OR: aluOperation = aluOr;
					`FN_XOR: aluOperation = aluXor;
					`FN_NOR: aluOperation = aluNor;
					`FN_SLT: aluOperation = aluCompare;
					`FN_SLTU: begin
						aluOperation = aluCompare;
						cmpSignal = `CMP_LTU;
					end
					default: instrClass = icInvalid;
				endcase
			end
			`OP_ADDIU: begin
				instrClass = icAluImm;
				aluOperation = aluAdd;
			end
			`OP_ADDI: begin
				instrClass = icAluImmOvf;
				aluOperation = aluAdd;
				aluSign = 2'b10;
			end
			`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
				instrClass = icAluImm;
				signExtend = 1'b0; // Logical immediates are zero extended
				case (opcode)
					`OP_ANDI: aluOperation = aluAnd;
					`OP_ORI: aluOperation = aluOr;
					`OP_XORI: aluOperation = aluXor;
					default: aluOperation = aluLui;
				endcase
			end
			`OP_SLTI, `OP_SLTIU: begin
				instrClass = icAluImm;
				aluOperation = aluCompare;
				cmpSignal = (opcode == `OP_SLTIU) ? `CMP_LTU : `CMP_LT;
			end
			`OP_LW, `OP_SW: begin
				instrClass = (opcode == `OP_LW) ? icLoad : icStore;
				aluOperation = aluAdd; // Base plus offset
			end
			`OP_BEQ, `OP_BNE: begin
				instrClass = icBranch;
				aluOperation = aluCompare;
				cmpSignal = (opcode == `OP_BEQ) ? `CMP_EQ : `CMP_NE;
			end
			`OP_J: instrClass = icJump;
			`OP_JAL: begin
				instrClass = icJumpLink;
				aluOperation = aluPcInc; // Return address into r31
			end
			default: instrClass = icInvalid;
		endcase
	end

	// Destination register
	always_comb begin
		case (instrClass)
			icAluReg, icAluRegOvf: regFileRD = instruction[`RD_HI:`RD_LO];
			icJumpLink: regFileRD = `LINK_REG;
			default: regFileRD = instruction[`RT_HI:`RT_LO];
		endcase
	end

endmodule

//--- hdl/branchTarget.sv
`timescale 1ns/10ps

module branchTarget import cuPkg::*; (
	input  logic        Clk,
	input  logic        arstN,
	input  logic [31:0] instruction,
	input  logic [31:0] currentPC,
	input  instrClass_t instrClass,
	input  logic        targetLoad,
	input  logic        fetchIssued,
	output logic [31:0] nextPC,
	output logic        pcSourceSel
);

	logic [31:0] branchAddr;
	logic [31:0] jumpAddr;
	logic        jumpPending; // Redirect waiting for the next fetch

	// currentPC already points past the branch
	assign branchAddr = currentPC + {{14{instruction[15]}}, instruction[15:0], 2'b00};
	assign jumpAddr = {currentPC[31:28], instruction[25:0], 2'b00};

	// Steer the PC mux only for the fetch right after the redirect
	assign pcSourceSel = jumpPending & fetchIssued;

	always_ff @(posedge Clk) begin
		if (targetLoad) begin
			nextPC <= (instrClass == icBranch) ? branchAddr : jumpAddr;
		end
	end

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			jumpPending <= 1'b0;
		end else if (targetLoad) begin
			jumpPending <= 1'b1;
		end else if (fetchIssued) begin
			jumpPending <= 1'b0;
		end
	end

endmodule

//--- hdl/controlSequencer.sv
`timescale 1ns/10ps
`include "cu_consts.svh"

module controlSequencer import cuPkg::*; (
	input  logic        Clk,
	input  logic        arstN,
	input  instrClass_t instrClass,
	input  logic [3:0]  aluFlags, // Bit 0 is overflow or compare result
	input  logic        ramMFC,
	output logic        clearPC,
	output logic        pcEnable,
	output logic        irEnable,
	output logic        marEnable,
	output logic        mdrEnable,
	output logic        ramMFA,
	output logic        ramRW,
	output logic [8:0]  ramAddress,
	output logic        trapMux,
	output logic        regFileRW,
	output aluBSel_t    aluBSel,
	output logic        mdrSel,
	output logic        targetLoad,
	output logic        fetchIssued
);

	cuState_t state;
	cuState_t nextState;
	logic     trapPending;
	logic     immOperand;
	logic     ovfClass;

	assign immOperand = (instrClass == icAluImm) || (instrClass == icAluImmOvf);
	assign ovfClass = (instrClass == icAluRegOvf) || (instrClass == icAluImmOvf);

	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			state <= stReset;
		end else begin
			state <= nextState;
		end
	end

	// Trap fetch keeps the vector on the bus until memory answers
	always_ff @(posedge Clk or negedge arstN) begin
		if (!arstN) begin
			trapPending <= 1'b0;
		end else if (state == stOvfCheck && aluFlags[0]) begin
			trapPending <= 1'b1;
		end else if (state == stFetchWait && ramMFC) begin
			trapPending <= 1'b0;
		end
	end

	always_comb begin
		nextState = state;
		clearPC = 1'b0;
		pcEnable = 1'b0;
		irEnable = 1'b0;
		marEnable = 1'b0;
		mdrEnable = 1'b0;
		ramMFA = 1'b0;
		ramRW = 1'b0;
		trapMux = 1'b0;
		regFileRW = 1'b0;
		aluBSel = bSelReg;
		mdrSel = 1'b0;
		targetLoad = 1'b0;
		fetchIssued = 1'b0;
		case (state)
			stReset: begin
				clearPC = 1'b1;
				nextState = stFetchAddr;
			end
			stFetchAddr: begin
				marEnable = 1'b1; // PC into MAR
				aluBSel = bSelPc;
				nextState = stFetchReq;
			end
			stFetchReq: begin
				pcEnable = 1'b1;
				ramMFA = 1'b1;
				fetchIssued = 1'b1;
				aluBSel = bSelPc;
				nextState = stFetchWait;
			end
			stFetchWait: begin
				ramMFA = 1'b1;
				trapMux = trapPending;
				if (ramMFC) begin
					nextState = stLoadIr;
				end
			end
			stLoadIr: begin
				irEnable = 1'b1;
				nextState = stDecode;
			end
			stDecode: begin
				case (instrClass)
					icAluReg, icAluRegOvf, icAluImm, icAluImmOvf: nextState = stAluExec;
					icLoad, icStore: nextState = stMemAddr;
					icBranch: nextState = stBranch;
					icJump: nextState = stJump;
					icJumpLink: nextState = stJumpLink;
					default: nextState = stFetchAddr; // Unknown code, fetch again
				endcase
			end
			stAluExec: begin
				aluBSel = immOperand ? bSelImm : bSelReg;
				if (ovfClass) begin
					nextState = stOvfCheck;
				end else begin
					regFileRW = 1'b1;
					nextState = stFetchAddr;
				end
			end
			stOvfCheck: begin
				aluBSel = immOperand ? bSelImm : bSelReg;
				if (aluFlags[0]) begin
					trapMux = 1'b1;
					ramMFA = 1'b1;
					nextState = stFetchWait;
				end else begin
					regFileRW = 1'b1;
					nextState = stFetchAddr;
				end
			end
			stMemAddr: begin
				marEnable = 1'b1;
				aluBSel = bSelImm;
				nextState = (instrClass == icStore) ? stStoreData : stMemWait;
			end
			stStoreData: begin
				mdrEnable = 1'b1; // rt through the ALU into MDR
				nextState = stMemWait;
			end
			stMemWait: begin
				ramMFA = 1'b1;
				ramRW = (instrClass == icStore);
				if (ramMFC) begin
					nextState = (instrClass == icStore) ? stFetchAddr : stMdrLoad;
				end
			end
			stMdrLoad: begin
				mdrEnable = 1'b1;
				mdrSel = 1'b1; // Capture RAM data
				nextState = stWriteBack;
			end
			stWriteBack: begin
				regFileRW = 1'b1;
				aluBSel = bSelMdr;
				nextState = stFetchAddr;
			end
			stBranch: begin
				targetLoad = aluFlags[0]; // Taken
				nextState = stFetchAddr;
			end
			stJump: begin
				targetLoad = 1'b1;
				nextState = stFetchAddr;
			end
			stJumpLink: begin
				targetLoad = 1'b1;
				regFileRW = 1'b1;
				aluBSel = bSelPc;
				nextState = stFetchAddr;
			end
			default: nextState = stReset;
		endcase
		ramAddress = trapMux ? `OVF_VECTOR : 9'd0;
	end

endmodule

//--- hdl/controlUnit.sv
`timescale 1ns/10ps
`include "cu_consts.svh"

module controlUnit import cuPkg::*; (
	input  logic              Clk,
	input  logic              arstN,
	input  logic [31:0]       instruction,
	input  logic [31:0]       currentPC,
	input  logic [3:0]        aluFlags,
	input  logic              ramMFC,
	output logic [`REG_W-1:0] regFileRS,
	output logic [`REG_W-1:0] regFileRT,
	output logic [`REG_W-1:0] regFileRD,
	output aluOp_t            aluOperation,
	output logic [1:0]        aluSign,
	output logic [3:0]        cmpSignal,
	output logic              signExtend,
	output logic [31:0]       nextPC,
	output logic              pcSourceSel,
	output logic              clearPC,
	output logic              pcEnable,
	output logic              irEnable,
	output logic              marEnable,
	output logic              mdrEnable,
	output logic              ramMFA,
	output logic              ramRW,
	output logic [8:0]        ramAddress,
	output logic              trapMux,
	output logic              regFileRW,
	output aluBSel_t          aluBSel,
	output logic              mdrSel
);

	instrClass_t instrClass;
	logic        targetLoad;
	logic        fetchIssued; // Consumes a pending redirect

	instrDecoder decoder (
		.instruction(instruction),
		.instrClass(instrClass),
		.regFileRS(regFileRS),
		.regFileRT(regFileRT),
		.regFileRD(regFileRD),
		.aluOperation(aluOperation),
		.aluSign(aluSign),
		.cmpSignal(cmpSignal),
		.signExtend(signExtend)
	);

	branchTarget target (
		.Clk(Clk),
		.arstN(arstN),
		.instruction(instruction),
		.currentPC(currentPC),
		.instrClass(instrClass),
		.targetLoad(targetLoad),
		.fetchIssued(fetchIssued),
		.nextPC(nextPC),
		.pcSourceSel(pcSourceSel)
	);

	controlSequencer sequencer (
		.Clk(Clk),
		.arstN(arstN),
		.instrClass(instrClass),
		.aluFlags(aluFlags),
		.ramMFC(ramMFC),
		.clearPC(clearPC),
		.pcEnable(pcEnable),
		.irEnable(irEnable),
		.marEnable(marEnable),
		.mdrEnable(mdrEnable),
		.ramMFA(ramMFA),
		.ramRW(ramRW),
		.ramAddress(ramAddress),
		.trapMux(trapMux),
		.regFileRW(regFileRW),
		.aluBSel(aluBSel),
		.mdrSel(mdrSel),
		.targetLoad(targetLoad),
		.fetchIssued(fetchIssued)
	);

endmodule

//--- testbench/controlUnit_checker.sv
`timescale 1ns/10ps

module controlUnit_checker (
	input logic Clk,
	input logic arstN,
	input logic ramMFA,
	input logic ramMFC,
	input logic irEnable,
	input logic regFileRW,
	input logic trapMux
);

	int failures = 0;

	// Request stays up until memory answers
	mfaHeld: assert property (@(posedge Clk) disable iff (!arstN)
		ramMFA && !ramMFC |=> ramMFA)
		else begin
			$error("ramMFA dropped before ramMFC");
			failures++;
		end

	irNoWrite: assert property (@(posedge Clk) disable iff (!arstN)
		!(irEnable && regFileRW))
		else begin
			$error("irEnable and regFileRW high in the same cycle");
			failures++;
		end

	trapNeedsMfa: assert property (@(posedge Clk) disable iff (!arstN)
		trapMux |-> ramMFA)
		else begin
			$error("trapMux high without a memory request");
			failures++;
		end

endmodule

bind controlUnit controlUnit_checker protocolCheck (
	.Clk(Clk),
	.arstN(arstN),
	.ramMFA(ramMFA),
	.ramMFC(ramMFC),
	.irEnable(irEnable),
	.regFileRW(regFileRW),
	.trapMux(trapMux)
);

//--- testbench/controlUnitMonitor.sv
`timescale 1ns/10ps
`include "cu_consts.svh"

module controlUnitMonitor import cuPkg::*; (
	input  logic        Clk,
	input  logic        arstN,
	input  logic        vecValid,
	input  logic [31:0] expWrite,
	input  logic [4:0]  expRd,
	input  logic [3:0]  expAluOp,
	input  logic        expTrap,
	input  logic [31:0] expNextPC,
	input  logic [31:0] instruction,
	input  logic [4:0]  regFileRS,
	input  logic [4:0]  regFileRT,
	input  logic [4:0]  regFileRD,
	input  aluOp_t      aluOperation,
	input  logic [1:0]  aluSign,
	input  logic [3:0]  cmpSignal,
	input  logic        signExtend,
	input  aluBSel_t    aluBSel,
	input  logic [31:0] nextPC,
	input  logic        pcSourceSel,
	input  logic        clearPC,
	input  logic        pcEnable,
	input  logic        irEnable,
	input  logic        marEnable,
	input  logic        mdrEnable,
	input  logic        mdrSel,
	input  logic        ramMFA,
	input  logic        ramRW,
	input  logic [8:0]  ramAddress,
	input  logic        trapMux,
	input  logic        regFileRW,
	output int          valueErrors,
	output int          otherErrors
);

	int   writes;
	int   clearCycles;
	logic clearChecked;
	logic sawTrap;
	logic sawPcSel;
	logic sawRamRW;
	logic sawMdrLoad;

	initial begin
		valueErrors = 0;
		otherErrors = 0;
		writes = 0;
		clearCycles = 0;
		clearChecked = 1'b0;
		sawTrap = 1'b0;
		sawPcSel = 1'b0;
		sawRamRW = 1'b0;
		sawMdrLoad = 1'b0;
	end

	task automatic reportValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
		valueErrors++;
	endtask

	task automatic reportOther(input string msg);
		$display("Error: %s at %0t", msg, $time);
		otherErrors++;
	endtask

	// ALU B source while the result goes to the register file
	function automatic aluBSel_t writeSource(input logic [5:0] opcode);
		case (opcode)
			`OP_RTYPE: return bSelReg;
			`OP_LW: return bSelMdr;
			`OP_JAL: return bSelPc;
			default: return bSelImm;
		endcase
	endfunction

	// Verdict for the instruction that ran since the last irEnable
	task automatic closeWindow();
		logic [5:0] opcode;
		logic [5:0] funct;
		logic       rType;
		logic       cmpOp;
		logic       immOp;
		logic [3:0] expCmp;
		logic [1:0] expSign;
		logic       expExt;
		opcode = instruction[31:26];
		funct = instruction[5:0];
		rType = (opcode == `OP_RTYPE);
		// Trapping adds are signed, sub and subu subtract
		expSign[1] = (rType && (funct == `FN_ADD || funct == `FN_SUB)) || opcode == `OP_ADDI;
		expSign[0] = rType && (funct == `FN_SUB || funct == `FN_SUBU);
		cmpOp = 1'b1;
		case (opcode)
			`OP_SLTI: expCmp = `CMP_LT;
			`OP_SLTIU: expCmp = `CMP_LTU;
			`OP_BEQ: expCmp = `CMP_EQ;
			`OP_BNE: expCmp = `CMP_NE;
			default: begin
				expCmp = (funct == `FN_SLTU) ? `CMP_LTU : `CMP_LT;
				cmpOp = rType && (funct == `FN_SLT || funct == `FN_SLTU);
			end
		endcase
		immOp = 1'b1;
		case (opcode)
			`OP_ANDI, `OP_ORI, `OP_XORI: expExt = 1'b0; // Logical forms zero extend
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_LW, `OP_SW, `OP_BEQ, `OP_BNE:
				expExt = 1'b1;
			default: begin
				expExt = 1'b1;
				immOp = 1'b0;
			end
		endcase
		if (regFileRS !== instruction[25:21])
			reportValue("regFileRS", 32'(instruction[25:21]), 32'(regFileRS));
		if (regFileRT !== instruction[20:16])
			reportValue("regFileRT", 32'(instruction[20:16]), 32'(regFileRT));
		if (aluSign !== expSign)
			reportValue("aluSign", 32'(expSign), 32'(aluSign));
		if (cmpOp && cmpSignal !== expCmp)
			reportValue("cmpSignal", 32'(expCmp), 32'(cmpSignal));
		if (immOp && signExtend !== expExt)
			reportValue("signExtend", 32'(expExt), 32'(signExtend));
		if (writes != int'(expWrite))
			reportValue("regFileRW pulses", expWrite, 32'(writes));
		if (sawTrap !== expTrap)
			reportValue("trapMux", 32'(expTrap), 32'(sawTrap));
		if ((expNextPC != 32'd0) && !sawPcSel)
			reportOther("redirect expected but pcSourceSel never rose");
		if ((expNextPC == 32'd0) && sawPcSel)
			reportOther("pcSourceSel rose for an instruction without redirect");
		if (opcode == `OP_LW && !sawMdrLoad)
			reportOther("load finished without an MDR capture");
		if (opcode == `OP_SW && !sawRamRW)
			reportOther("store never issued a write request");
		if (opcode != `OP_SW && sawRamRW)
			reportOther("write request from an instruction that is not a store");
	endtask

	always @(posedge Clk) begin
		if (!arstN) begin
			if (pcEnable | irEnable | marEnable | mdrEnable | ramMFA | ramRW | regFileRW
				| trapMux | pcSourceSel)
				reportOther("control output active during reset");
			clearCycles = 0;
		end else begin
			if (clearPC)
				clearCycles++;
			if (!clearChecked && !marEnable && (pcEnable | irEnable | mdrEnable | ramMFA
				| ramRW | regFileRW | trapMux | pcSourceSel))
				reportOther("control output active before the first fetch");
			if (marEnable && !clearChecked) begin // First fetch address
				if (clearCycles != 1)
					reportOther("clearPC not high for exactly one cycle after reset");
				clearChecked = 1'b1;
			end
			if (pcEnable && aluBSel !== bSelPc)
				reportValue("aluBSel", 32'(bSelPc), 32'(aluBSel));
			if (regFileRW) begin
				writes++;
				if (vecValid && regFileRD !== expRd)
					reportValue("regFileRD", 32'(expRd), 32'(regFileRD));
				if (vecValid && aluOperation !== expAluOp)
					reportValue("aluOperation", 32'(expAluOp), 32'(aluOperation));
				if (vecValid && aluBSel !== writeSource(instruction[31:26]))
					reportValue("aluBSel", 32'(writeSource(instruction[31:26])),
						32'(aluBSel));
			end
			if (trapMux) begin
				sawTrap = 1'b1;
				if (ramAddress !== 9'd448)
					reportValue("ramAddress", 32'd448, 32'(ramAddress));
			end
			if (pcSourceSel) begin
				sawPcSel = 1'b1;
				if (vecValid && nextPC !== expNextPC)
					reportValue("nextPC", expNextPC, nextPC);
			end
			if (ramMFA && ramRW)
				sawRamRW = 1'b1;
			if (mdrEnable && mdrSel)
				sawMdrLoad = 1'b1;
			if (irEnable) begin
				if (vecValid)
					closeWindow();
				writes = 0;
				sawTrap = 1'b0;
				sawPcSel = 1'b0;
				sawRamRW = 1'b0;
				sawMdrLoad = 1'b0;
			end
		end
	end

endmodule

//--- testbench/controlUnitTb.sv
`timescale 1ns/10ps

module controlUnitTb import cuPkg::*; ();

	localparam int MAX_VEC = 64;
	localparam int FIELDS = 9; // Words per stimulus line

	logic        Clk;
	logic        arstN;
	logic [31:0] instruction;
	logic [31:0] currentPC;
	logic [3:0]  aluFlags;
	logic        ramMFC;
	logic [4:0]  regFileRS, regFileRT, regFileRD;
	aluOp_t      aluOperation;
	logic [1:0]  aluSign;
	logic [3:0]  cmpSignal;
	logic        signExtend, pcSourceSel, clearPC, pcEnable, irEnable;
	logic        marEnable, mdrEnable, ramMFA, ramRW, trapMux, regFileRW, mdrSel;
	logic [31:0] nextPC;
	logic [8:0]  ramAddress;
	aluBSel_t    aluBSel;

	logic [31:0] vecMem [0:MAX_VEC*FIELDS-1];
	logic        vecValid, expTrap;
	logic [31:0] expWrite, expNextPC;
	logic [4:0]  expRd;
	logic [3:0]  expAluOp;
	int          vecCount, vecIndex, maxWait, memWait, waitCount;
	int          cycleLimit, cycleCount, valueErrors, otherErrors;
	logic        finished, irSeen, mfaSeen, mfcSeen;

	controlUnit DUT (.*);

	controlUnitMonitor monitor (.*);

	task automatic applyVector(input int idx);
		instruction = vecMem[idx*FIELDS];
		currentPC = vecMem[idx*FIELDS+1];
		aluFlags = vecMem[idx*FIELDS+2][3:0];
		memWait = int'(vecMem[idx*FIELDS+3]);
		expWrite = vecMem[idx*FIELDS+4];
		expRd = vecMem[idx*FIELDS+5][4:0];
		expAluOp = vecMem[idx*FIELDS+6][3:0];
		expTrap = vecMem[idx*FIELDS+7][0];
		expNextPC = vecMem[idx*FIELDS+8];
		vecValid = 1'b1;
	endtask

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	initial begin
		arstN = 1'b0;
		instruction = 32'd0;
		currentPC = 32'd0;
		aluFlags = 4'd0;
		ramMFC = 1'b0;
		vecValid = 1'b0;
		expWrite = 32'd0;
		expRd = 5'd0;
		expAluOp = 4'd0;
		expTrap = 1'b0;
		expNextPC = 32'd0;
		memWait = 1; // First fetch, before any vector
		waitCount = 0;
		vecIndex = -1;
		finished = 1'b0;
		cycleCount = 0;
		$readmemh("testbench/cu_stimulus.txt", vecMem);
		vecCount = 0;
		maxWait = 1;
		while (vecCount < MAX_VEC && vecMem[vecCount*FIELDS] !== 32'hx) begin
			if (int'(vecMem[vecCount*FIELDS+3]) > maxWait)
				maxWait = int'(vecMem[vecCount*FIELDS+3]);
			vecCount++;
		end
		if (vecCount == 0)
			$display("No stimulus vectors could be read");
		cycleLimit = 4 + (vecCount + 1) * (12 + maxWait);
		repeat (4) @(posedge Clk);
		#2 arstN = 1'b1;
		while (!finished && vecCount > 0 && cycleCount < cycleLimit) begin
			@(posedge Clk);
			irSeen = irEnable;
			mfaSeen = ramMFA;
			mfcSeen = ramMFC;
			#2;
			cycleCount++;
			// Memory model answers after the vector's wait
			if (mfcSeen) begin
				ramMFC = 1'b0;
				waitCount = 0;
			end else if (mfaSeen) begin
				waitCount++;
				if (waitCount >= memWait)
					ramMFC = 1'b1;
			end
			if (irSeen) begin
				if (vecIndex == vecCount - 1) begin
					finished = 1'b1;
				end else begin
					vecIndex++;
					applyVector(vecIndex);
				end
			end
		end
		if (!finished && vecCount > 0)
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
		$display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			valueErrors, otherErrors, DUT.protocolCheck.failures);
		if (finished && valueErrors == 0 && otherErrors == 0
			&& DUT.protocolCheck.failures == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- testbench/cu_stimulus.txt
// instruction currentPC aluFlags memWait | expected: writes rd aluOp trap nextPC
// nextPC 0 means no redirect expected
00221821 00400010 0 1 1 03 1 0 00000000
00C72824 00400014 0 1 1 05 4 0 00000000
012A402A 00400018 0 2 1 08 D 0 00000000
24240005 0040001C 0 2 1 04 1 0 00000000
3C071234 00400020 0 1 1 07 A 0 00000000
344900FF 00400024 0 1 1 09 5 0 00000000
00221820 00400028 1 3 0 03 1 1 00000000
00221820 0040002C 0 1 1 03 1 0 00000000
2024FFFF 00400030 1 2 0 04 1 1 00000000
8C260008 00400034 0 3 1 06 1 0 00000000
AC260004 00400038 0 2 0 06 1 0 00000000
10220004 00400010 1 1 0 02 D 0 00400020
1422FFFE 00400100 1 1 0 02 D 0 004000F8
10220004 00400040 0 1 0 02 D 0 00000000
08100040 10000004 0 1 0 00 0 0 10400100
0C000010 00400020 0 2 1 1F B 0 00000040
FC000000 00400048 0 1 0 00 0 0 00000000
0000003F 0040004C 0 1 0 00 0 0 00000000

//--- src.f
+incdir+hdl
hdl/cuPkg.sv
hdl/instrDecoder.sv
hdl/branchTarget.sv
hdl/controlSequencer.sv
hdl/controlUnit.sv
testbench/controlUnit_checker.sv
testbench/controlUnitMonitor.sv
testbench/controlUnitTb.sv

//--- Makefile
# Verilator simulation of the control unit testbench

VERILATOR ?= verilator
TOP       ?= controlUnitTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG); then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
